// ==== flist.f ====
cpuPkg.sv
busCtrlIf.sv
aluNet.sv
busRegs.sv
progMem.sv
microSeq.sv
cpuTop.sv
tbCpu.sv

// ==== cpuTrace.txt ====
# P addr byte loads memory, E value queues an expected output, G runs from 0
# R addrA addrB loads two random operands and queues their sum, all numbers hex
# Operands shared by the programs
P 80 F0
P 81 20
P 82 01
P 83 00
P 84 81
P 85 03
# Halt at once, no output
P 00 0F
G
# Shifter, ADD/ADC chain, SUB/SBC
P 00 01 # LDA 84
P 01 84
P 02 08 # SHR
P 03 0A
P 04 01 # LDA 80
P 05 80
P 06 02 # LDB 81
P 07 81
P 08 04 # ADD
P 09 0A
P 0A 01 # LDA 82
P 0B 82
P 0C 02 # LDB 83
P 0D 83
P 0E 05 # ADC
P 0F 0A
P 10 09 # ROR
P 11 0A
P 12 02 # LDB 81
P 13 81
P 14 06 # SUB
P 15 0A
P 16 07 # SBC
P 17 0A
P 18 0F
E 40
E 10
E 02
E 81
E 61
E 40
G
# Countdown with JZ and JMP, then JC taken and not taken
P 00 01 # LDA 85
P 01 85
P 02 02 # LDB 82
P 03 82
P 04 0A # Loop
P 05 06
P 06 0C # JZ 0A
P 07 0A
P 08 0B # JMP 04
P 09 04
P 0A 0D # JC 0D
P 0B 0D
P 0C 0A # Skipped
P 0D 06
P 0E 0D # JC 11
P 0F 11
P 10 0A
P 11 0F
E 03
E 02
E 01
E FF
G
# Random ADD, stored with STA and read back with LDA
P 00 01 # LDA 86
P 01 86
P 02 02 # LDB 87
P 03 87
P 04 04 # ADD
P 05 03 # STA 88
P 06 88
P 07 01 # LDA 83
P 08 83
P 09 0A
P 0A 01 # LDA 88
P 0B 88
P 0C 0A
P 0D 0F
E 00
R 86 87
G

// ==== tbCpu.sv ====
module tbCpu;

   localparam int timeoutCycles = 2000;

   logic                         clk;
   logic                         rstN;
   logic                         loadEn;
   logic [cpuPkg::dataWidth-1:0] loadAddr;
   logic [cpuPkg::dataWidth-1:0] loadData;
   logic                         run;
   logic                         halted;
   logic [cpuPkg::dataWidth-1:0] outValue;
   logic                         outStrobe;

   logic [cpuPkg::dataWidth-1:0] expQ[$]; // Expected outputs of the next program
   integer                       errors;
   integer                       timeouts;
   integer                       progNum;
   integer                       seed;
   logic                         hung;

   integer                       fd;
   integer                       code;
   logic                         done;
   logic [8*16-1:0]              tok;
   logic [8*128-1:0]             lineBuf;
   logic [cpuPkg::dataWidth-1:0] addr;
   logic [cpuPkg::dataWidth-1:0] val;

   cpuTop DUT (
      .clk       (clk),
      .rstN      (rstN),
      .loadEn    (loadEn),
      .loadAddr  (loadAddr),
      .loadData  (loadData),
      .run       (run),
      .halted    (halted),
      .outValue  (outValue),
      .outStrobe (outStrobe)
   );

   always #4 clk = ~clk;

   task automatic loadByte(input logic [cpuPkg::dataWidth-1:0] a,
                           input logic [cpuPkg::dataWidth-1:0] d);
      loadEn   = 1'b1;
      loadAddr = a;
      loadData = d;
      @(posedge clk);
      #1;
      loadEn = 1'b0;
   endtask

   // Sum kept to 8 bits, the carry out is dropped
   task automatic loadRandomPair(input logic [cpuPkg::dataWidth-1:0] addrA,
                                 input logic [cpuPkg::dataWidth-1:0] addrB);
      integer                       rnd;
      logic [cpuPkg::dataWidth-1:0] opA;
      logic [cpuPkg::dataWidth-1:0] opB;
      logic [cpuPkg::dataWidth-1:0] sum;
      rnd = $random(seed);
      opA = rnd[7:0];
      rnd = $random(seed);
      opB = rnd[7:0];
      sum = opA + opB;
      loadByte(addrA, opA);
      loadByte(addrB, opB);
      expQ.push_back(sum);
   endtask

   task automatic runProgram();
      integer cycles;
      integer idx;
      logic   stopped;
      cycles  = 0;
      idx     = 0;
      stopped = 1'b0;
      progNum++;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      assert (halted === 1'b0) else begin
         $display("FAILED at time %0t: program %0d did not start after run", $time, progNum);
         errors++;
      end
      while (!stopped && cycles < timeoutCycles) begin
         @(posedge clk);
         #1;
         cycles++;
         if (outStrobe) begin
            assert (idx < expQ.size()) else begin
               $display("Program %0d gave an unexpected output 0x%02h at time %0t",
                        progNum, outValue, $time);
               errors++;
            end
            if (idx < expQ.size()) begin
               assert (outValue === expQ[idx]) else begin
                  $display("FAILED at time %0t: program %0d output %0d is 0x%02h, expected 0x%02h",
                           $time, progNum, idx, outValue, expQ[idx]);
                  errors++;
               end
            end
            idx++;
         end
         stopped = (halted === 1'b1);
      end
      if (!stopped) begin
         $display("Program %0d hung: halted did not rise within %0d cycles",
                  progNum, timeoutCycles);
         timeouts++;
         hung = 1'b1;
      end else begin
         assert (idx >= expQ.size()) else begin
            $display("Program %0d halted after %0d of %0d expected outputs",
                     progNum, idx, expQ.size());
            errors++;
         end
      end
      expQ.delete();
   endtask

   initial begin
      clk      = 1'b0;
      rstN     = 1'b0;
      loadEn   = 1'b0;
      loadAddr = '0;
      loadData = '0;
      run      = 1'b0;
      errors   = 0;
      timeouts = 0;
      progNum  = 0;
      seed     = 32'he8a22cfb;
      hung     = 1'b0;
      done     = 1'b0;
      repeat (10) @(posedge clk);
      #1;
      rstN = 1'b1;
      repeat (4) begin
         assert (halted === 1'b1 && outStrobe === 1'b0) else begin
            $display("FAILED at time %0t: halted or output strobe wrong after reset", $time);
            errors++;
         end
         @(posedge clk);
         #1;
      end
      fd = $fopen("cpuTrace.txt", "r");
      if (fd == 0) begin
         $display("Could not open cpuTrace.txt");
         errors++;
         done = 1'b1;
      end
      while (!done) begin
         code = $fscanf(fd, "%s", tok);
         if (code != 1) begin
            done = 1'b1;
         end else if (tok == "#") begin
            code = $fgets(lineBuf, fd); // Rest of a comment
         end else if (tok == "P") begin
            code = $fscanf(fd, "%h %h", addr, val);
            loadByte(addr, val);
         end else if (tok == "E") begin
            code = $fscanf(fd, "%h", val);
            expQ.push_back(val);
         end else if (tok == "R") begin
            code = $fscanf(fd, "%h %h", addr, val);
            loadRandomPair(addr, val);
         end else if (tok == "G") begin
            runProgram();
            done = hung; // Loader is locked out while the CPU runs
         end else begin
            $display("Unknown command %0s in cpuTrace.txt", tok);
            errors++;
            done = 1'b1;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== cpuTop.sv ====
module cpuTop (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         loadEn,
   input  logic [cpuPkg::dataWidth-1:0] loadAddr,
   input  logic [cpuPkg::dataWidth-1:0] loadData,
   input  logic                         run,
   output logic                         halted,
   output logic [cpuPkg::dataWidth-1:0] outValue,
   output logic                         outStrobe
);

   wire  [cpuPkg::dataWidth-1:0] dbus; // Shared tri-state bus
   logic [cpuPkg::dataWidth-1:0] areg;
   logic [cpuPkg::dataWidth-1:0] breg;
   logic                         aIsZero;
   logic                         flagCarry;

   aluCtrlIf aluCtrl ();
   regCtrlIf regCtrl ();

   microSeq uSeq (
      .clk       (clk),
      .rstN      (rstN),
      .run       (run),
      .dbus      (dbus),
      .aIsZero   (aIsZero),
      .flagCarry (flagCarry),
      .aluCtrl   (aluCtrl.seq),
      .regCtrl   (regCtrl.seq),
      .halted    (halted)
   );

   aluNet uAlu (
      .clk       (clk),
      .rstN      (rstN),
      .ctrl      (aluCtrl.alu),
      .areg      (areg),
      .breg      (breg),
      .dbus      (dbus),
      .aIsZero   (aIsZero),
      .flagCarry (flagCarry),
      .flagShift ()
   );

   busRegs uRegs (
      .clk       (clk),
      .rstN      (rstN),
      .ctrl      (regCtrl.regs),
      .dbus      (dbus),
      .areg      (areg),
      .breg      (breg),
      .outValue  (outValue),
      .outStrobe (outStrobe)
   );

   progMem uMem (
      .clk      (clk),
      .ctrl     (regCtrl.mem),
      .dbus     (dbus),
      .loadEn   (loadEn),
      .loadAddr (loadAddr),
      .loadData (loadData),
      .halted   (halted)
   );

endmodule

// ==== microSeq.sv ====
module microSeq (
   input  logic                         clk,
   input  logic                         rstN,
   input  logic                         run,
   input  logic [cpuPkg::dataWidth-1:0] dbus,
   input  logic                         aIsZero,
   input  logic                         flagCarry,
   aluCtrlIf.seq                        aluCtrl,
   regCtrlIf.seq                        regCtrl,
   output logic                         halted
);

   logic [cpuPkg::dataWidth-1:0] pc;
   logic [cpuPkg::dataWidth-1:0] mar;
   cpuPkg::opcodeT               ir;
   cpuPkg::stepT                 step;
   cpuPkg::stepT                 stepNext;

   logic marFromPc;
   logic marFromBus;
   logic irLoad;
   logic pcInc;
   logic pcLoad;
   logic setHalt;

   assign regCtrl.memAddr = mar;

   always_comb begin
      aluCtrl.doSubtract = 1'b0;
      aluCtrl.doCarryIn  = 1'b0;
      aluCtrl.doShiftIn  = 1'b0;
      aluCtrl.assertBarE = 1'b1;
      aluCtrl.assertBarS = 1'b1;
      aluCtrl.triggerC   = 1'b0;
      aluCtrl.triggerS   = 1'b0;
      regCtrl.loadA      = 1'b0;
      regCtrl.loadB      = 1'b0;
      regCtrl.loadOut    = 1'b0;
      regCtrl.assertBarA = 1'b1;
      regCtrl.memOe      = 1'b0;
      regCtrl.memWe      = 1'b0;
      marFromPc  = 1'b0;
      marFromBus = 1'b0;
      irLoad     = 1'b0;
      pcInc      = 1'b0;
      pcLoad     = 1'b0;
      setHalt    = 1'b0;
      stepNext   = cpuPkg::stepT0;
      if (!halted) begin
         case (step)
            cpuPkg::stepT0: begin
               marFromPc = 1'b1;
               stepNext  = cpuPkg::stepT1;
            end
            cpuPkg::stepT1: begin // Opcode fetch
               regCtrl.memOe = 1'b1;
               irLoad        = 1'b1;
               pcInc         = 1'b1;
               stepNext      = cpuPkg::stepT2;
            end
            cpuPkg::stepT2: begin
               case (ir)
                  cpuPkg::opLda, cpuPkg::opLdb, cpuPkg::opSta,
                  cpuPkg::opJmp, cpuPkg::opJz, cpuPkg::opJc: begin
                     marFromPc = 1'b1; // Point at operand byte
                     stepNext  = cpuPkg::stepT3;
                  end
                  cpuPkg::opNop: begin
                     stepNext = cpuPkg::stepT0;
                  end
                  cpuPkg::opAdd, cpuPkg::opAdc, cpuPkg::opSub, cpuPkg::opSbc: begin
                     aluCtrl.doSubtract = (ir == cpuPkg::opSub) || (ir == cpuPkg::opSbc);
                     aluCtrl.doCarryIn  = (ir == cpuPkg::opAdc) || (ir == cpuPkg::opSbc);
                     aluCtrl.assertBarE = 1'b0;
                     aluCtrl.triggerC   = 1'b1;
                     regCtrl.loadA      = 1'b1;
                  end
                  cpuPkg::opShr, cpuPkg::opRor: begin
                     aluCtrl.doShiftIn  = (ir == cpuPkg::opRor);
                     aluCtrl.assertBarS = 1'b0;
                     aluCtrl.triggerS   = 1'b1;
                     regCtrl.loadA      = 1'b1;
                  end
                  cpuPkg::opOut: begin
                     regCtrl.assertBarA = 1'b0;
                     regCtrl.loadOut    = 1'b1;
                  end
                  default: begin
                     setHalt = 1'b1; // HLT and unknown bytes
                  end
               endcase
            end
            cpuPkg::stepT3: begin // Operand byte on the bus
               regCtrl.memOe = 1'b1;
               case (ir)
                  cpuPkg::opJmp: pcLoad = 1'b1;
                  cpuPkg::opJz:  pcLoad = aIsZero;
                  cpuPkg::opJc:  pcLoad = flagCarry;
                  default: begin
                     marFromBus = 1'b1;
                     stepNext   = cpuPkg::stepT4;
                  end
               endcase
               pcInc = !pcLoad;
            end
            cpuPkg::stepT4: begin
               case (ir)
                  cpuPkg::opLda: begin
                     regCtrl.memOe = 1'b1;
                     regCtrl.loadA = 1'b1;
                  end
                  cpuPkg::opLdb: begin
                     regCtrl.memOe = 1'b1;
                     regCtrl.loadB = 1'b1;
                  end
                  default: begin
                     regCtrl.assertBarA = 1'b0;
                     regCtrl.memWe      = 1'b1;
                  end
               endcase
            end
            default: stepNext = cpuPkg::stepT0;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         mar    <= '0;
         ir     <= cpuPkg::opNop;
         step   <= cpuPkg::stepT0;
         halted <= 1'b1;
      end else if (run) begin // Restart at address 0
         pc     <= '0;
         step   <= cpuPkg::stepT0;
         halted <= 1'b0;
      end else begin
         step <= stepNext;
         if (setHalt) begin
            halted <= 1'b1;
         end
         if (marFromPc) begin
            mar <= pc;
         end else if (marFromBus) begin
            mar <= dbus;
         end
         if (irLoad) begin
            ir <= cpuPkg::opcodeT'(dbus);
         end
         if (pcLoad) begin
            pc <= dbus;
         end else if (pcInc) begin
            pc <= pc + 1'b1;
         end
      end
   end

endmodule

// ==== progMem.sv ====
module progMem (
   input  logic                         clk,
   regCtrlIf.mem                        ctrl,
   inout  wire  [cpuPkg::dataWidth-1:0] dbus,
   input  logic                         loadEn,
   input  logic [cpuPkg::dataWidth-1:0] loadAddr,
   input  logic [cpuPkg::dataWidth-1:0] loadData,
   input  logic                         halted
);

   logic [cpuPkg::dataWidth-1:0] mem [cpuPkg::memDepth];
   logic                         wrEn;
   logic [cpuPkg::dataWidth-1:0] wrAddr;
   logic [cpuPkg::dataWidth-1:0] wrData;

   // Asynchronous read onto the bus
   assign dbus = ctrl.memOe ? mem[ctrl.memAddr] : 'z;

   // Loader port only reaches the array while the CPU is stopped
   always_comb begin
      wrEn   = 1'b0;
      wrAddr = ctrl.memAddr;
      wrData = dbus;
      if (ctrl.memWe) begin
         wrEn = 1'b1;
      end else if (loadEn && halted) begin
         wrEn   = 1'b1;
         wrAddr = loadAddr;
         wrData = loadData;
      end
   end

   always_ff @(posedge clk) begin
      if (wrEn) begin
         mem[wrAddr] <= wrData;
      end
   end

endmodule

// ==== busRegs.sv ====
module busRegs (
   input  logic                         clk,
   input  logic                         rstN,
   regCtrlIf.regs                       ctrl,
   inout  wire  [cpuPkg::dataWidth-1:0] dbus,
   output logic [cpuPkg::dataWidth-1:0] areg,
   output logic [cpuPkg::dataWidth-1:0] breg,
   output logic [cpuPkg::dataWidth-1:0] outValue,
   output logic                         outStrobe
);

   // A line driver
   assign dbus = !ctrl.assertBarA ? areg : 'z;

   always_ff @(posedge clk) begin
      if (ctrl.loadA) begin
         areg <= dbus;
      end
      if (ctrl.loadB) begin
         breg <= dbus;
      end
      if (ctrl.loadOut) begin
         outValue <= dbus; // Valid with the strobe
      end
   end

   // One cycle pulse per OUT
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         outStrobe <= 1'b0;
      end else begin
         outStrobe <= ctrl.loadOut;
      end
   end

endmodule

// ==== aluNet.sv ====
module aluNet (
   input  logic                         clk,
   input  logic                         rstN,
   aluCtrlIf.alu                        ctrl,
   input  logic [cpuPkg::dataWidth-1:0] areg,
   input  logic [cpuPkg::dataWidth-1:0] breg,
   inout  wire  [cpuPkg::dataWidth-1:0] dbus,
   output logic                         aIsZero,
   output logic                         flagCarry,
   output logic                         flagShift
);

   logic [cpuPkg::dataWidth-1:0] other;
   logic [cpuPkg::dataWidth:0]   sum;
   logic [cpuPkg::dataWidth-1:0] shifted;
   logic                         cin;
   logic                         carryOrBorrowIn;
   logic                         shiftIn;

   // B inverted for subtract
   assign other = breg ^ {cpuPkg::dataWidth{ctrl.doSubtract}};

   // Stored carry gated in, then flipped for subtract
   assign cin             = flagCarry & ctrl.doCarryIn;
   assign carryOrBorrowIn = cin ^ ctrl.doSubtract;

   // Bit 8 is the raw adder carry-out
   assign sum = {1'b0, areg} + {1'b0, other} + {{cpuPkg::dataWidth{1'b0}}, carryOrBorrowIn};

   assign shiftIn = flagShift & ctrl.doShiftIn;
   assign shifted = {shiftIn, areg[cpuPkg::dataWidth-1:1]};

   assign aIsZero = (areg == '0);

   // Bus line drivers
   assign dbus = !ctrl.assertBarE ? sum[cpuPkg::dataWidth-1:0] : 'z;
   assign dbus = !ctrl.assertBarS ? shifted : 'z;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         flagCarry <= 1'b0;
      end else if (ctrl.triggerC) begin
         flagCarry <= sum[cpuPkg::dataWidth];
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         flagShift <= 1'b0;
      end else if (ctrl.triggerS) begin
         flagShift <= areg[0]; // Bit shifted out of A
      end
   end

endmodule

// ==== busCtrlIf.sv ====
interface aluCtrlIf;
   logic doSubtract;
   logic doCarryIn;
   logic doShiftIn;
   logic assertBarE; // Sum onto bus, active low
   logic assertBarS; // Shifter onto bus, active low
   logic triggerC;
   logic triggerS;

   modport seq (output doSubtract, doCarryIn, doShiftIn, assertBarE, assertBarS,
                triggerC, triggerS);
   modport alu (input doSubtract, doCarryIn, doShiftIn, assertBarE, assertBarS,
                triggerC, triggerS);
endinterface

interface regCtrlIf;
   logic loadA;
   logic loadB;
   logic loadOut;
   logic assertBarA; // A onto bus, active low
   logic memOe;
   logic memWe;
   logic [cpuPkg::dataWidth-1:0] memAddr;

   modport seq  (output loadA, loadB, loadOut, assertBarA, memOe, memWe, memAddr);
   modport regs (input loadA, loadB, loadOut, assertBarA);
   modport mem  (input memOe, memWe, memAddr);
endinterface

// ==== cpuPkg.sv ====
package cpuPkg;

   localparam int dataWidth = 8; // Bus, register and address width
   localparam int memDepth  = 256;

   // Address-carrying opcodes take one operand byte after the opcode
   typedef enum logic [dataWidth-1:0] {
      opNop = 8'h00,
      opLda = 8'h01, // A <= mem[addr]
      opLdb = 8'h02, // B <= mem[addr]
      opSta = 8'h03, // mem[addr] <= A
      opAdd = 8'h04,
      opAdc = 8'h05, // Carry flag in
      opSub = 8'h06,
      opSbc = 8'h07, // Borrow from carry flag
      opShr = 8'h08, // Zero in at bit 7
      opRor = 8'h09, // Shift flag in at bit 7
      opOut = 8'h0A,
      opJmp = 8'h0B,
      opJz  = 8'h0C, // Taken when A is zero
      opJc  = 8'h0D, // Taken when carry set
      opHlt = 8'h0F
   } opcodeT;

   // T0 and T1 fetch, T2 executes or addresses the operand
   typedef enum logic [2:0] {
      stepT0 = 3'd0,
      stepT1 = 3'd1,
      stepT2 = 3'd2,
      stepT3 = 3'd3,
      stepT4 = 3'd4
   } stepT;

endpackage
